// ==== include/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000 // first fetch after reset

`endif

// ==== rtl/isaPkg.sv ====
package isaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011, // lb lh lw lbu lhu
        opImm    = 7'b0010011, // immediate alu ops
        opStore  = 7'b0100011, // sb sh sw
        opReg    = 7'b0110011, // register alu ops
        opLui    = 7'b0110111,
        opBranch = 7'b1100011, // beq bne
        opJal    = 7'b1101111
    } opcodeT;

    typedef logic [2:0] funct3T; // codes overlap across classes, so no enum

    // alu class
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101; // funct7 bit picks sra
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // load and store sizes
    localparam funct3T f3Byte  = 3'b000;
    localparam funct3T f3Half  = 3'b001;
    localparam funct3T f3Word  = 3'b010;
    localparam funct3T f3ByteU = 3'b100; // loads only
    localparam funct3T f3HalfU = 3'b101; // loads only

    // branch compares
    localparam funct3T f3Beq = 3'b000;
    localparam funct3T f3Bne = 3'b001;

    typedef struct packed {
        opcodeT      opcode; // raw[6:0]
        logic [4:0]  rd;     // raw[11:7]
        funct3T      funct3; // raw[14:12]
        logic [4:0]  rs1;    // raw[19:15]
        logic [4:0]  rs2;    // raw[24:20]
        logic        funct7; // raw[30] only, sub and sra
        logic [31:0] raw;    // whole word, immediate source
    } instrFieldsT;

endpackage

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB // lui, immediate straight through
    } aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelT;

    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultSrcT;

    typedef struct packed {
        logic          regWrite;
        aluOpT         aluCtrl;
        logic          aluSrc;    // 1 selects immediate for operand b
        immSelT        immSrc;
        logic          pcSrc;     // 1 takes pc + immediate
        logic          memWrite;
        resultSrcT     resultSrc;
        isaPkg::funct3T memSize;  // funct3 of loads and stores
    } ctrlWordT;

    // everything off, used as decoder default
    localparam ctrlWordT ctrlIdle = '{
        regWrite:  1'b0,
        aluCtrl:   aluAdd,
        aluSrc:    1'b0,
        immSrc:    immI,
        pcSrc:     1'b0,
        memWrite:  1'b0,
        resultSrc: resAlu,
        memSize:   '0
    };

endpackage

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                arstN,
    output logic [`XLEN-1:0]    imemAddr,
    input  logic [`XLEN-1:0]    imemData,
    input  ctrlPkg::ctrlWordT   ctrl,
    input  logic [`XLEN-1:0]    immediate,
    output isaPkg::instrFieldsT fields,
    output logic [`XLEN-1:0]    pc,
    output logic [`XLEN-1:0]    pcPlus4
);
    import isaPkg::*;

    logic [`XLEN-1:0] pcTarget; // branch or jump destination
    logic [`XLEN-1:0] pcNext;

    // program counter, one instruction per edge
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= `RESET_PC;
        else
            pc <= pcNext;
    end

    assign pcPlus4  = pc + `XLEN'(4);                 // sequential path, also jal link
    assign pcTarget = pc + immediate;                 // B or J immediate, already sign extended
    assign pcNext   = ctrl.pcSrc ? pcTarget : pcPlus4;
    assign imemAddr = pc;                             // combinational imem read

    // slice fetched word into decode fields
    always_comb
    begin
        fields.opcode = opcodeT'(imemData[6:0]); // unknown codes pass as raw value
        fields.rd     = imemData[11:7];
        fields.funct3 = imemData[14:12];
        fields.rs1    = imemData[19:15];
        fields.rs2    = imemData[24:20];
        fields.funct7 = imemData[30];           // only bit that matters here
        fields.raw    = imemData;
    end

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
    input  isaPkg::instrFieldsT fields,
    input  logic                eq,     // rs1 == rs2 from execute
    output ctrlPkg::ctrlWordT   ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    // funct3/funct7 to alu op for register and immediate forms
    function automatic aluOpT aluDecode(input funct3T f3, input logic f7, input logic isReg);
        aluOpT op;
        case (f3)
            f3AddSub: op = (isReg && f7) ? aluSub : aluAdd; // addi has no sub
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = f7 ? aluSra : aluSrl;           // imm[10] for srai
            f3Or:     op = aluOr;
            default:  op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl = ctrlIdle; // all inactive unless decoded below

        case (fields.opcode)
            opReg:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluDecode(fields.funct3, fields.funct7, 1'b1);
            end
            opImm:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immI;
                ctrl.aluCtrl  = aluDecode(fields.funct3, fields.funct7, 1'b0);
            end
            opLoad:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;   // rs1 + offset
                ctrl.immSrc    = immI;
                ctrl.resultSrc = resMem;
                ctrl.memSize   = fields.funct3;
            end
            opStore:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immS;    // split offset
                ctrl.memWrite = 1'b1;
                ctrl.memSize  = fields.funct3;
            end
            opBranch:
            begin
                ctrl.immSrc = immB;
                // taken on beq with eq and bne without
                ctrl.pcSrc  = ((fields.funct3 == f3Beq) && eq) ||
                              ((fields.funct3 == f3Bne) && !eq);
            end
            opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.aluCtrl  = aluPassB; // upper immediate as is
            end
            opJal:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;       // alu forms pc + offset
                ctrl.immSrc    = immJ;
                ctrl.pcSrc     = 1'b1;       // always taken
                ctrl.resultSrc = resPcPlus4; // link value
            end
            default:
            begin
                ctrl = ctrlIdle; // unknown opcode does nothing
            end
        endcase
    end

endmodule

// ==== rtl/executeUnit.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module executeUnit (
    input  logic                clk,
    input  logic                arstN,
    input  isaPkg::instrFieldsT fields,
    input  ctrlPkg::ctrlWordT   ctrl,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    writeData,  // from writeback select
    output logic [`XLEN-1:0]    aluResult,
    output logic [`XLEN-1:0]    rs2Data,
    output logic [`XLEN-1:0]    immediate,
    output logic                eq
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [4:0]       shamt;
    logic             regWe;
    logic [31:0]      raw;

    assign raw = fields.raw;

    // register file, x0 never written so it stays zero
    assign regWe = ctrl.regWrite & arstN;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (regWe && (fields.rd != 5'd0))
        begin
            regs[fields.rd] <= writeData;
        end
    end

    assign rs1Data = regs[fields.rs1]; // async read
    assign rs2Data = regs[fields.rs2]; // also store data
    assign eq      = (rs1Data == rs2Data);

    // immediate per format, sign taken from raw[31]
    always_comb
    begin
        case (ctrl.immSrc)
            immI:    immediate = {{20{raw[31]}}, raw[31:20]};
            immS:    immediate = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            immB:    immediate = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            immU:    immediate = {raw[31:12], 12'b0};
            immJ:    immediate = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            default: immediate = '0;
        endcase
    end

    // jal runs pc through operand a, aluResult then shows the jump target
    assign srcA  = (fields.opcode == opJal) ? pc : rs1Data;
    assign srcB  = ctrl.aluSrc ? immediate : rs2Data;
    assign shamt = srcB[4:0]; // low five bits only

    always_comb
    begin
        case (ctrl.aluCtrl)
            aluAdd:   aluResult = srcA + srcB;
            aluSub:   aluResult = srcA - srcB;
            aluAnd:   aluResult = srcA & srcB;
            aluOr:    aluResult = srcA | srcB;
            aluXor:   aluResult = srcA ^ srcB;
            aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  aluResult = {{(`XLEN-1){1'b0}}, srcA < srcB};
            aluSll:   aluResult = srcA << shamt;
            aluSrl:   aluResult = srcA >> shamt;
            aluSra:   aluResult = $signed(srcA) >>> shamt; // sign fill
            aluPassB: aluResult = srcB;
            default:  aluResult = srcA + srcB;
        endcase
    end

endmodule

// ==== rtl/memAccessUnit.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module memAccessUnit (
    input  logic              arstN,
    input  ctrlPkg::ctrlWordT ctrl,
    input  logic [`XLEN-1:0]  aluResult,      // effective address or alu value
    input  logic [`XLEN-1:0]  rs2Data,
    input  logic [`XLEN-1:0]  pcPlus4,
    output logic [`XLEN-1:0]  dmemAddr,
    output logic [`XLEN-1:0]  dmemWriteData,
    output logic [3:0]        dmemByteEnable,
    output logic              dmemWrite,
    input  logic [`XLEN-1:0]  dmemReadData,
    output logic [`XLEN-1:0]  writeData
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [1:0]       byteOff;
    logic [`XLEN-1:0] byteLane;  // addressed byte moved to bits 7:0
    logic [`XLEN-1:0] halfLane;  // addressed half moved to bits 15:0
    logic [`XLEN-1:0] loadData;

    assign byteOff   = aluResult[1:0];
    assign dmemAddr  = {aluResult[`XLEN-1:2], 2'b00}; // word aligned
    assign dmemWrite = ctrl.memWrite & arstN;

    // store lane placement, enables only on a real write
    always_comb
    begin
        dmemWriteData  = rs2Data;
        dmemByteEnable = 4'b0000;
        if (dmemWrite)
        begin
            case (ctrl.memSize)
                f3Byte:
                begin
                    dmemWriteData  = rs2Data << {byteOff, 3'b000};
                    dmemByteEnable = 4'b0001 << byteOff;
                end
                f3Half:
                begin
                    dmemWriteData  = rs2Data << {byteOff[1], 4'b0000};
                    dmemByteEnable = 4'b0011 << {byteOff[1], 1'b0}; // upper or lower half
                end
                default:
                begin
                    dmemByteEnable = 4'b1111; // sw
                end
            endcase
        end
    end

    // load extraction and extension
    assign byteLane = dmemReadData >> {byteOff, 3'b000};
    assign halfLane = dmemReadData >> {byteOff[1], 4'b0000};

    always_comb
    begin
        case (ctrl.memSize)
            f3Byte:  loadData = {{24{byteLane[7]}}, byteLane[7:0]};
            f3Half:  loadData = {{16{halfLane[15]}}, halfLane[15:0]};
            f3ByteU: loadData = {24'b0, byteLane[7:0]};
            f3HalfU: loadData = {16'b0, halfLane[15:0]};
            default: loadData = dmemReadData; // lw
        endcase
    end

    // writeback select
    always_comb
    begin
        case (ctrl.resultSrc)
            resMem:     writeData = loadData;
            resPcPlus4: writeData = pcPlus4;   // jal link
            default:    writeData = aluResult;
        endcase
    end

endmodule

// ==== rtl/riscvCore.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module riscvCore (
    input  logic             clk,
    input  logic             arstN,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [`XLEN-1:0] imemData,
    output logic [`XLEN-1:0] dmemAddr,
    output logic [`XLEN-1:0] dmemWriteData,
    output logic [3:0]       dmemByteEnable,
    output logic             dmemWrite,
    input  logic [`XLEN-1:0] dmemReadData
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrFieldsT      fields;     // decoded instruction
    ctrlWordT         ctrl;       // control word for this cycle
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] immediate;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] writeData;  // writeback into regfile
    logic             eq;

    // input side
    fetchUnit fetch (
        .clk       (clk),
        .arstN     (arstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .ctrl      (ctrl),
        .immediate (immediate),
        .fields    (fields),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    // processing
    controlUnit control (
        .fields (fields),
        .eq     (eq),
        .ctrl   (ctrl)
    );

    executeUnit execute (
        .clk       (clk),
        .arstN     (arstN),
        .fields    (fields),
        .ctrl      (ctrl),
        .pc        (pc),
        .writeData (writeData),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .immediate (immediate),
        .eq        (eq)
    );

    // output side
    memAccessUnit memAccess (
        .arstN          (arstN),
        .ctrl           (ctrl),
        .aluResult      (aluResult),
        .rs2Data        (rs2Data),
        .pcPlus4        (pcPlus4),
        .dmemAddr       (dmemAddr),
        .dmemWriteData  (dmemWriteData),
        .dmemByteEnable (dmemByteEnable),
        .dmemWrite      (dmemWrite),
        .dmemReadData   (dmemReadData),
        .writeData      (writeData)
    );

endmodule

// ==== sim/riscvCore_asserts.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module riscvCore_asserts (
    input logic             clk,
    input logic             arstN,
    input logic [`XLEN-1:0] imemAddr,
    input logic [3:0]       dmemByteEnable,
    input logic             dmemWrite,
    input logic             pcSrc
);
    int failCount = 0; // failed assertion count

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) imemAddr[1:0] == 2'b00)
        else
        begin
            $error("pc 0x%h is not word aligned", imemAddr);
            failCount++;
        end

    enableIdle: assert property (@(posedge clk) !dmemWrite |-> dmemByteEnable == 4'b0000)
        else
        begin
            $error("byte enables 0x%h without a write", dmemByteEnable);
            failCount++;
        end

    resetNoWrite: assert property (@(posedge clk) !arstN |-> !dmemWrite)
        else
        begin
            $error("dmem write during reset");
            failCount++;
        end

    // sequential fetch unless branch or jump taken
    pcStep: assert property (@(posedge clk) disable iff (!arstN)
                             !pcSrc |=> imemAddr == $past(imemAddr) + `XLEN'(4))
        else
        begin
            $error("pc did not advance by 4");
            failCount++;
        end

endmodule

bind riscvCore riscvCore_asserts checks (
    .clk            (clk),
    .arstN          (arstN),
    .imemAddr       (imemAddr),
    .dmemByteEnable (dmemByteEnable),
    .dmemWrite      (dmemWrite),
    .pcSrc          (ctrl.pcSrc)
);

// ==== sim/riscvCore_tb.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module riscvCore_tb;
    import isaPkg::*;

    localparam int instrTotal = 99;                            // words programmed over all tests
    localparam int watchdogNs = instrTotal * 10 * 2;           // two clock periods per word
    localparam logic [29:0] aluF3List = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  aluAltList = 10'b00_1000_0010;     // sub and sra

    logic             clk;
    logic             arstN;
    logic [`XLEN-1:0] imemAddr;
    logic [`XLEN-1:0] imemData;
    logic [`XLEN-1:0] dmemAddr;
    logic [`XLEN-1:0] dmemWriteData;
    logic [3:0]       dmemByteEnable;
    logic             dmemWrite;
    logic [`XLEN-1:0] dmemReadData;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] expWord [64]; // expected dmem words
    int          redirect [64]; // pc offset taken at a slot or 0 to fall through
    logic [31:0] pcLog [$];     // imemAddr seen at each edge
    logic [3:0]  beLog [$];     // byte enables of each store
    int          wp;            // next free imem slot
    int          errors;
    int          testErrors;
    int          testsRun;
    int          testsFailed;

    riscvCore DUT (.*);

    assign imemData     = imem[imemAddr[7:2]];  // combinational fetch
    assign dmemReadData = dmem[dmemAddr[7:2]];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // dmem write port and edge logs
    always @(posedge clk)
    begin
        if (dmemWrite)
        begin
            for (int i = 0; i < 4; i++)
                if (dmemByteEnable[i])
                    dmem[dmemAddr[7:2]][8 * i +: 8] <= dmemWriteData[8 * i +: 8];
            beLog.push_back(dmemByteEnable);
        end
        if (arstN)
            pcLog.push_back(imemAddr);
    end

    initial
    begin
        #(watchdogNs);
        $display("timeout: the tests did not finish within %0d ns", watchdogNs);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opLui};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        return 32'h5a00_0000 ^ (i * 32'h0003_0107); // differs for every word
    endfunction

    // rv32i alu semantics with b[4:0] as shift amount
    function automatic logic [31:0] expectedAlu(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrors == 0)
            $display("test %s passed", name);
        else
        begin
            $display("test %s failed with %0d mismatches", name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[wp] = word;
        wp++;
    endtask

    task automatic emitConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12; // offsets the sign of the addi part
        emit(encU(upper[19:0], rd));
        emit(encI(v[11:0], rd, f3AddSub, rd, opImm));
    endtask

    // load from word 16 at offset and store the result to slot
    task automatic emitLoadStore(input logic [2:0] f3, input int off, input int slot);
        emit(encI(12'(64 + off), 0, f3, 6, opLoad));
        emit(encS(12'(4 * slot), 6, 0, f3Word));
    endtask

    task automatic emitBranch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] v1, input logic [31:0] v2);
        redirect[wp] = ((f3 == f3Beq) ? (v1 == v2) : (v1 != v2)) ? 8 : 0;
        emit(encB(13'd8, rs2, rs1, f3));
    endtask

    // hold the core in reset while both memories are rewritten
    task automatic resetAndClear();
        arstN = 1'b0;
        wp    = 0;
        for (int i = 0; i < 64; i++)
        begin
            imem[i]     = encI(12'd0, 0, f3AddSub, 0, opImm); // nop
            dmem[i]    <= fillWord(i);
            redirect[i] = 0;
        end
    endtask

    // walk the program for the pc sequence and then run and compare
    task automatic runProgram();
        logic [31:0] p;
        logic [31:0] expPc [$];
        int          idx;
        p = `RESET_PC;
        while ((p - `RESET_PC) / 4 < wp)
        begin
            expPc.push_back(p);
            idx = (p - `RESET_PC) / 4;
            p   = p + ((redirect[idx] != 0) ? redirect[idx] : 4);
        end
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        pcLog.delete();
        beLog.delete();
        repeat (expPc.size()) @(negedge clk); // one instruction per cycle
        foreach (expPc[i])
            checkValue($sformatf("imemAddr[%0d]", i), pcLog[i], expPc[i]);
    endtask

    task automatic aluTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        int          slot;
        a = $urandom | 32'h8000_0000; // negative rs1
        b = $urandom;
        resetAndClear();
        emitConst(1, a);
        emitConst(2, b);
        slot = 0;
        for (int k = 0; k < 10; k++)
        begin
            f3  = aluF3List[3 * k +: 3];
            alt = aluAltList[k];
            emit(encR({1'b0, alt, 5'b0}, 2, 1, f3, 3));
            emit(encS(12'(4 * slot), 3, 0, f3Word));
            expWord[slot] = expectedAlu(f3, alt, a, b);
            slot++;
            if (k == 1)
                continue; // no subi
            imm = $urandom;
            if (f3 == f3Sll || f3 == f3SrlSra)
                imm = {1'b0, alt, 5'b0, imm[4:0]}; // shamt form with bit 10 for srai
            emit(encI(imm, 1, f3, 3, opImm));
            emit(encS(12'(4 * slot), 3, 0, f3Word));
            expWord[slot] = expectedAlu(f3, alt, a, {{20{imm[11]}}, imm});
            slot++;
        end
        runProgram();
        for (int i = 0; i < slot; i++)
            checkValue($sformatf("dmem[%0d]", i), dmem[i], expWord[i]);
        endTest("alu");
    endtask

    task automatic luiTest();
        logic [31:0] c;
        c = $urandom | 32'h0000_0800; // addi part negative
        resetAndClear();
        emitConst(5, c);
        emit(encS(12'd0, 5, 0, f3Word));
        emitConst(0, ~c);             // into x0 and dropped
        emit(encS(12'd4, 0, 0, f3Word));
        runProgram();
        checkValue("dmem[0]", dmem[0], c);
        checkValue("dmem[1]", dmem[1], 32'h0);
        endTest("lui");
    endtask

    task automatic loadTest();
        logic [31:0] w;
        logic [31:0] lane;
        int          slot;
        w = ($urandom & 32'h7f7f_7f7f) | 32'h8000_0080; // bytes 0 and 3 negative
        resetAndClear();
        dmem[16] <= w;
        slot = 0;
        for (int off = 0; off < 4; off++)
        begin
            lane = w >> (8 * off);
            emitLoadStore(f3Byte, off, slot);
            expWord[slot] = {{24{lane[7]}}, lane[7:0]};
            emitLoadStore(f3ByteU, off, slot + 1);
            expWord[slot + 1] = {24'b0, lane[7:0]};
            slot += 2;
            if (off % 2 == 0)
            begin
                emitLoadStore(f3Half, off, slot);
                expWord[slot] = {{16{lane[15]}}, lane[15:0]};
                emitLoadStore(f3HalfU, off, slot + 1);
                expWord[slot + 1] = {16'b0, lane[15:0]};
                slot += 2;
            end
        end
        runProgram();
        for (int i = 0; i < slot; i++)
            checkValue($sformatf("dmem[%0d]", i), dmem[i], expWord[i]);
        endTest("load");
    endtask

    task automatic storeTest();
        logic [31:0] v;
        logic [31:0] word;
        logic [3:0]  expBe [$];
        v = $urandom;
        resetAndClear();
        emitConst(7, v);
        for (int off = 0; off < 4; off++)
        begin
            emit(encS(12'(4 * (20 + off) + off), 7, 0, f3Byte)); // own word per offset
            word = fillWord(20 + off);
            word[8 * off +: 8] = v[7:0];
            expWord[20 + off] = word;
            expBe.push_back(4'b0001 << off);
        end
        for (int h = 0; h < 2; h++)
        begin
            emit(encS(12'(4 * (24 + h) + 2 * h), 7, 0, f3Half));
            word = fillWord(24 + h);
            word[16 * h +: 16] = v[15:0];
            expWord[24 + h] = word;
            expBe.push_back(4'b0011 << (2 * h));
        end
        runProgram();
        for (int i = 20; i < 26; i++)
            checkValue($sformatf("dmem[%0d]", i), dmem[i], expWord[i]);
        checkValue("beLog.size", beLog.size(), expBe.size());
        foreach (expBe[i])
            checkValue($sformatf("dmemByteEnable[%0d]", i), beLog[i], expBe[i]);
        endTest("store");
    endtask

    task automatic branchTest();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom;
        b = a ^ ($urandom | 32'h1); // never equal to a
        resetAndClear();
        emitConst(1, a);
        emitConst(2, a);
        emitConst(3, b);
        emitBranch(f3Beq, 1, 2, a, a);
        emit(encS(12'd0, 1, 0, f3Word));  // skipped
        emitBranch(f3Beq, 1, 3, a, b);
        emit(encS(12'd4, 1, 0, f3Word));
        emitBranch(f3Bne, 1, 3, a, b);
        emit(encS(12'd8, 1, 0, f3Word));  // skipped
        emitBranch(f3Bne, 1, 2, a, a);
        emit(encS(12'd12, 3, 0, f3Word));
        runProgram();
        checkValue("dmem[0]", dmem[0], fillWord(0));
        checkValue("dmem[1]", dmem[1], a);
        checkValue("dmem[2]", dmem[2], fillWord(2));
        checkValue("dmem[3]", dmem[3], b);
        endTest("branch");
    endtask

    task automatic jalTest();
        resetAndClear();
        emit(encI(12'd0, 0, f3AddSub, 0, opImm));
        redirect[wp] = 12;
        emit(encJ(21'd12, 4));            // jal x4 at pc 4
        emit(encS(12'd0, 4, 0, f3Word));  // jumped over
        emit(encS(12'd0, 4, 0, f3Word));
        emit(encS(12'd4, 4, 0, f3Word));
        runProgram();
        checkValue("first imemAddr", pcLog[0], `RESET_PC);
        checkValue("dmem[0]", dmem[0], fillWord(0));
        checkValue("dmem[1]", dmem[1], `RESET_PC + 32'd8); // link is pc + 4
        endTest("jal");
    endtask

    initial
    begin
        arstN       = 1'b0;
        errors      = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        void'($urandom(32'hfe7a_eba5));
        aluTest();
        luiTest();
        loadTest();
        storeTest();
        branchTest();
        jalTest();
        errors = errors + DUT.checks.failCount;
        $display("%0d tests, %0d failed, %0d errors, %0d of them from assertions",
                 testsRun, testsFailed, errors, DUT.checks.failCount);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== riscvCore.f ====
+incdir+include
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/fetchUnit.sv
rtl/controlUnit.sv
rtl/executeUnit.sv
rtl/memAccessUnit.sv
rtl/riscvCore.sv
sim/riscvCore_asserts.sv
sim/riscvCore_tb.sv
